//--- vlog.f
hdl/mips_pkg.sv
hdl/mips_alu.sv
hdl/mips_regfile.sv
hdl/mips_cpu.sv
hdl/avalon_ram.sv
hdl/mips_subsystem.sv
testbench/mips_subsystem_assert.sv
testbench/mips_subsystem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass message.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module mips_subsystem_tb -Mdir obj_dir -f vlog.f \
    && ./obj_dir/Vmips_subsystem_tb | tee /dev/stderr | grep -x "test passed" > /dev/null \
    && echo "Simulation run succeeded" \
    || { echo "Simulation run failed"; exit 1; }

//--- testbench/mips_subsystem_tb.sv
`timescale 1ns/1ps

module mips_subsystem_tb;

    localparam int RAM_WORDS  = 256;
    localparam int RAM_WAIT   = 2;
    localparam int NUM_FIXED  = 8;
    localparam int NUM_RANDOM = 6;
    localparam int NUM_ROWS   = NUM_FIXED + NUM_RANDOM;
    // Slowest instruction is fetch, execute, memory and writeback.
    localparam int INSTR_CYCLES    = 2 * (RAM_WAIT + 1) + 2;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 40 * INSTR_CYCLES;
    localparam int HOLD_CYCLES     = 20;

    // One stimulus row, sw/lw round trip when is_mem is set.
    typedef struct packed {
        logic             is_mem;
        mips_pkg::funct_e fn;
        logic [15:0]      imm_a;
        logic [15:0]      imm_b;
        mips_pkg::word_t  exp_v0;
    } row_t;

    logic            clk;
    logic            rst_n;
    logic            active;
    mips_pkg::word_t register_v0;
    logic            load_en;
    logic [7:0]      load_addr;
    mips_pkg::word_t load_data;

    row_t            rows [NUM_ROWS];
    mips_pkg::word_t program_words [4];
    logic [31:0]     rng_state;
    int              errors;
    int              rows_ok;
    int              rows_bad;
    int              assert_fails;

    mips_subsystem #(
        .RAM_WORDS (RAM_WORDS),
        .RAM_WAIT  (RAM_WAIT)
    ) u_mips_subsystem (
        .clk         (clk),
        .rst_n       (rst_n),
        .active      (active),
        .register_v0 (register_v0),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic mips_pkg::word_t sign_extend(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    // Value of $2 after addiu $3, addiu $4 and the R-type op.
    function automatic mips_pkg::word_t alu_rule(input mips_pkg::funct_e fn,
                                                 input logic [15:0] a,
                                                 input logic [15:0] b);
        mips_pkg::word_t x;
        mips_pkg::word_t y;
        mips_pkg::word_t r;
        x = sign_extend(a);
        y = sign_extend(b);
        case (fn)
            mips_pkg::FN_SUBU: r = x - y;
            mips_pkg::FN_AND:  r = x & y;
            mips_pkg::FN_OR:   r = x | y;
            mips_pkg::FN_XOR:  r = x ^ y;
            default:           r = x + y;
        endcase
        return r;
    endfunction

    function automatic row_t make_row(input logic is_mem, input mips_pkg::funct_e fn,
                                      input logic [15:0] a, input logic [15:0] b,
                                      input mips_pkg::word_t exp_v0);
        row_t r;
        r.is_mem = is_mem;
        r.fn     = fn;
        r.imm_a  = a;
        r.imm_b  = b;
        r.exp_v0 = exp_v0;
        return r;
    endfunction

    function automatic string describe_row(input row_t r);
        string s;
        case (r.fn)
            mips_pkg::FN_SUBU: s = "subu";
            mips_pkg::FN_AND:  s = "and";
            mips_pkg::FN_OR:   s = "or";
            mips_pkg::FN_XOR:  s = "xor";
            default:           s = "addu";
        endcase
        if (r.is_mem) begin
            s = "sw/lw";
        end
        return s;
    endfunction

    task automatic build_table();
        logic [15:0]      a;
        logic [15:0]      b;
        mips_pkg::funct_e fn;
        rows[0] = make_row(1'b0, mips_pkg::FN_ADDU, 16'h0005, 16'h0007, 32'h0000_000C);
        rows[1] = make_row(1'b0, mips_pkg::FN_SUBU, 16'h0003, 16'h0005, 32'hFFFF_FFFE);
        rows[2] = make_row(1'b0, mips_pkg::FN_AND, 16'h0FF0, 16'h00FF, 32'h0000_00F0);
        rows[3] = make_row(1'b0, mips_pkg::FN_OR, 16'h1200, 16'h0034, 32'h0000_1234);
        // addiu sign-extends 0xF0F0 before the xor.
        rows[4] = make_row(1'b0, mips_pkg::FN_XOR, 16'hF0F0, 16'h00FF, 32'hFFFF_F00F);
        rows[5] = make_row(1'b0, mips_pkg::FN_OR, 16'h8000, 16'h0000, 32'hFFFF_8000);
        rows[6] = make_row(1'b1, mips_pkg::FN_ADDU, 16'h5A5A, 16'h0100, 32'h0000_5A5A);
        rows[7] = make_row(1'b1, mips_pkg::FN_ADDU, 16'hBEEF, 16'h0104, 32'hFFFF_BEEF);
        for (int i = NUM_FIXED; i < NUM_ROWS; i++) begin
            rng_state = xorshift(rng_state);
            a = rng_state[15:0];
            rng_state = xorshift(rng_state);
            b = rng_state[15:0];
            rng_state = xorshift(rng_state);
            case (rng_state % 5)
                0:       fn = mips_pkg::FN_ADDU;
                1:       fn = mips_pkg::FN_SUBU;
                2:       fn = mips_pkg::FN_AND;
                3:       fn = mips_pkg::FN_OR;
                default: fn = mips_pkg::FN_XOR;
            endcase
            rows[i] = make_row(1'b0, fn, a, b, alu_rule(fn, a, b));
        end
    endtask

    // Four words, ending in jr $0.
    task automatic assemble_program(input row_t r);
        program_words[0] = {mips_pkg::OP_ADDIU, 5'd0, 5'd3, r.imm_a};
        if (r.is_mem) begin
            program_words[1] = {mips_pkg::OP_SW, 5'd0, 5'd3, r.imm_b};
            program_words[2] = {mips_pkg::OP_LW, 5'd0, 5'd2, r.imm_b};
        end else begin
            program_words[1] = {mips_pkg::OP_ADDIU, 5'd0, 5'd4, r.imm_b};
            // rs $3, rt $4, rd $2.
            program_words[2] = {mips_pkg::OP_SPECIAL, 5'd3, 5'd4, 5'd2, 5'd0, r.fn};
        end
        program_words[3] = {mips_pkg::OP_SPECIAL, 5'd0, 5'd0, 5'd0, 5'd0, mips_pkg::FN_JR};
    endtask

    task automatic check_word(input mips_pkg::word_t actual, input mips_pkg::word_t expected,
                              input string what);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic run_row(input int idx);
        row_t r;
        int   errors_before;
        r = rows[idx];
        errors_before = errors;
        assemble_program(r);
        @(posedge clk);
        rst_n <= 1'b0;
        // Preload one word per edge while reset is held.
        for (int i = 0; i < 4; i++) begin
            load_en   <= 1'b1;
            load_addr <= 8'(mips_pkg::RESET_VECTOR) + 8'(4 * i);
            load_data <= program_words[i];
            @(negedge clk);
            check_bit(active, 1'b0, "active during reset");
            @(posedge clk);
        end
        load_en <= 1'b0;
        rst_n   <= 1'b1;
        @(negedge clk);
        check_bit(active, 1'b0, "active before first edge");
        @(negedge clk);
        check_bit(active, 1'b1, "active after first edge");
        while (active) begin
            @(negedge clk);
        end
        check_word(register_v0, r.exp_v0, "register_v0 at halt");
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            check_bit(active, 1'b0, "active after halt");
            check_word(register_v0, r.exp_v0, "register_v0 after halt");
        end
        if (errors == errors_before) begin
            rows_ok++;
            $display("row %0d %s: ok, register_v0 = %h", idx, describe_row(r), register_v0);
        end else begin
            rows_bad++;
            $display("row %0d %s: mismatch", idx, describe_row(r));
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        rng_state = 32'h118b;
        errors    = 0;
        rows_ok   = 0;
        rows_bad  = 0;
        build_table();
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        assert_fails = int'(u_mips_subsystem.u_mips_cpu.u_mips_subsystem_assert.assert_errors);
        $display("%0d rows ok, %0d rows with errors, %0d assertion failures",
                 rows_ok, rows_bad, assert_fails);
        if ((rows_bad == 0) && (errors == 0) && (assert_fails == 0)) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Ends a run where the processor never reaches jr $0.
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the processor never halted",
                 WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule

//--- testbench/mips_subsystem_assert.sv
`timescale 1ns/1ps

module mips_subsystem_assert (
    input logic                  clk,
    input logic                  rst_n,
    input mips_pkg::avalon_req_t bus_req,
    input logic                  waitrequest,
    input logic                  active
);

    int unsigned assert_errors = 0;
    logic        active_q;
    logic        halted;

    // Set once active falls, cleared only by reset.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            halted   <= 1'b0;
        end else begin
            active_q <= active;
            if (active_q && !active) begin
                halted <= 1'b1;
            end
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (bus_req.read || bus_req.write) && waitrequest |=> $stable(bus_req))
    else begin
        $error("Avalon request changed while waitrequest was high");
        assert_errors++;
    end

    a_no_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
        !(bus_req.read && bus_req.write))
    else begin
        $error("Avalon read and write asserted together");
        assert_errors++;
    end

    a_halt_held: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !active)
    else begin
        $error("active rose again after the processor halted");
        assert_errors++;
    end

endmodule

bind mips_cpu mips_subsystem_assert u_mips_subsystem_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .bus_req     (bus_req),
    .waitrequest (waitrequest),
    .active      (active)
);

//--- hdl/mips_subsystem.sv
`timescale 1ns/1ps

module mips_subsystem #(
    parameter int RAM_WORDS = 256,
    parameter int RAM_WAIT  = 2
) (
    input  logic            clk,
    input  logic            rst_n,
    output logic            active,
    output mips_pkg::word_t register_v0,
    input  logic            load_en,
    input  logic [7:0]      load_addr,
    input  mips_pkg::word_t load_data
);

    // Avalon bus between processor and RAM.
    mips_pkg::avalon_req_t bus_req;
    logic                  waitrequest;
    mips_pkg::word_t       readdata;

    mips_cpu u_mips_cpu (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus_req     (bus_req),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .active      (active),
        .register_v0 (register_v0)
    );

    avalon_ram #(
        .RAM_WORDS (RAM_WORDS),
        .RAM_WAIT  (RAM_WAIT)
    ) u_avalon_ram (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus_req     (bus_req),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data)
    );

endmodule

//--- hdl/avalon_ram.sv
`timescale 1ns/1ps

module avalon_ram #(
    parameter int RAM_WORDS = 256,
    parameter int RAM_WAIT  = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mips_pkg::avalon_req_t bus_req,
    output logic                  waitrequest,
    output mips_pkg::word_t       readdata,
    input  logic                  load_en,
    input  logic [7:0]            load_addr,
    input  mips_pkg::word_t       load_data
);

    localparam int ADDR_W = $clog2(RAM_WORDS);
    localparam int CNT_W  = (RAM_WAIT > 0) ? $clog2(RAM_WAIT + 1) : 1;

    mips_pkg::word_t    mem [RAM_WORDS];
    logic [CNT_W-1:0]   wait_cnt;
    logic               access;
    logic [ADDR_W-1:0]  bus_idx;
    logic [ADDR_W-1:0]  load_idx;

    // Word addressing, byte offset bits dropped.
    assign bus_idx  = bus_req.address[ADDR_W+1:2];
    assign load_idx = ADDR_W'(load_addr[7:2]);
    assign access   = bus_req.read || bus_req.write;

    // Stall until RAM_WAIT cycles of the access have passed.
    assign waitrequest = access && (wait_cnt != CNT_W'(RAM_WAIT));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (waitrequest) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            // Completed or idle, next access starts a fresh count.
            wait_cnt <= '0;
        end
    end

    // Contents survive reset so the preloaded program is kept.
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_idx] <= load_data;
        end else if (bus_req.write && !waitrequest) begin
            for (int b = 0; b < 4; b++) begin
                if (bus_req.byteenable[b]) begin
                    mem[bus_idx][8*b +: 8] <= bus_req.writedata[8*b +: 8];
                end
            end
        end
    end

    // Valid in the cycle waitrequest is low.
    assign readdata = mem[bus_idx];

endmodule

//--- hdl/mips_cpu.sv
`timescale 1ns/1ps

module mips_cpu (
    input  logic                  clk,
    input  logic                  rst_n,
    output mips_pkg::avalon_req_t bus_req,
    input  logic                  waitrequest,
    input  mips_pkg::word_t       readdata,
    output logic                  active,
    output mips_pkg::word_t       register_v0
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_EXEC,
        S_MEM,
        S_WB,
        S_HALT
    } state_e;

    state_e state;

    mips_pkg::word_t pc;
    mips_pkg::word_t ir;
    mips_pkg::word_t alu_out;
    mips_pkg::word_t mdr;

    mips_pkg::opcode_e opcode;
    mips_pkg::funct_e  funct;
    mips_pkg::alu_op_e alu_op;
    mips_pkg::word_t   imm_ext;
    mips_pkg::word_t   alu_b;
    mips_pkg::word_t   alu_result;
    mips_pkg::word_t   rs_data;
    mips_pkg::word_t   rt_data;

    logic is_rtype;
    logic is_jr;
    logic is_addiu;
    logic is_lw;
    logic is_sw;
    logic wr_en;
    logic [4:0] wr_addr;
    mips_pkg::word_t wr_data;

    // Instruction decode.
    assign opcode   = mips_pkg::opcode_e'(ir[31:26]);
    assign funct    = mips_pkg::funct_e'(ir[5:0]);
    assign imm_ext  = {{16{ir[15]}}, ir[15:0]};
    assign is_rtype = (opcode == mips_pkg::OP_SPECIAL);
    assign is_jr    = is_rtype && (funct == mips_pkg::FN_JR);
    assign is_addiu = (opcode == mips_pkg::OP_ADDIU);
    assign is_lw    = (opcode == mips_pkg::OP_LW);
    assign is_sw    = (opcode == mips_pkg::OP_SW);

    always_comb begin
        alu_op = mips_pkg::ALU_ADD;
        if (is_rtype) begin
            case (funct)
                mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
                mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
                mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
                mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
                default:           alu_op = mips_pkg::ALU_ADD;
            endcase
        end
    end

    // R-type takes rt, everything else the immediate.
    assign alu_b = is_rtype ? rt_data : imm_ext;

    // Writeback.
    assign wr_en   = (state == S_WB) && (is_addiu || is_lw || (is_rtype && !is_jr));
    assign wr_addr = is_rtype ? ir[15:11] : ir[20:16];
    assign wr_data = is_lw ? mdr : alu_out;

    mips_alu u_mips_alu (
        .a      (rs_data),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result)
    );

    mips_regfile u_mips_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (ir[25:21]),
        .rt_addr (ir[20:16]),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .v0      (register_v0)
    );

    // Control FSM and program counter.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            pc    <= mips_pkg::RESET_VECTOR;
        end else begin
            case (state)
                S_IDLE: begin
                    state <= S_FETCH;
                end
                S_FETCH: begin
                    if (!waitrequest) begin
                        state <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    if (is_jr) begin
                        pc    <= rs_data;
                        // Jump to address 0 stops the processor.
                        state <= (rs_data == '0) ? S_HALT : S_WB;
                    end else begin
                        pc    <= pc + 32'd4;
                        state <= (is_lw || is_sw) ? S_MEM : S_WB;
                    end
                end
                S_MEM: begin
                    if (!waitrequest) begin
                        state <= S_WB;
                    end
                end
                S_WB: begin
                    state <= S_FETCH;
                end
                default: begin
                    state <= S_HALT;
                end
            endcase
        end
    end

    // Datapath registers.
    always_ff @(posedge clk) begin
        if ((state == S_FETCH) && !waitrequest) begin
            ir <= readdata;
        end
        if (state == S_EXEC) begin
            alu_out <= alu_result;
        end
        if ((state == S_MEM) && !waitrequest) begin
            mdr <= readdata;
        end
    end

    // Request is a function of registered state only, so it holds under waitrequest.
    always_comb begin
        bus_req            = '0;
        bus_req.byteenable = 4'hF;
        bus_req.writedata  = rt_data;
        if (state == S_FETCH) begin
            bus_req.address = pc;
            bus_req.read    = 1'b1;
        end else if (state == S_MEM) begin
            bus_req.address = alu_out;
            bus_req.read    = is_lw;
            bus_req.write   = is_sw;
        end
    end

    assign active = (state != S_IDLE) && (state != S_HALT);

endmodule

//--- hdl/mips_regfile.sv
`timescale 1ns/1ps

module mips_regfile (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [4:0]      rs_addr,
    input  logic [4:0]      rt_addr,
    output mips_pkg::word_t rs_data,
    output mips_pkg::word_t rt_data,
    input  logic            wr_en,
    input  logic [4:0]      wr_addr,
    input  mips_pkg::word_t wr_data,
    output mips_pkg::word_t v0
);

    mips_pkg::word_t regs [32];

    // Register 0 is never written, so it stays at its reset value of zero.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != 5'd0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Combinational read ports.
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    // Result register tap.
    assign v0 = regs[2];

endmodule

//--- hdl/mips_alu.sv
`timescale 1ns/1ps

module mips_alu (
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    input  mips_pkg::alu_op_e op,
    output mips_pkg::word_t   result
);

    // Shared by R-type ops, addiu and the lw/sw address add.
    always_comb begin
        case (op)
            mips_pkg::ALU_ADD: begin
                result = a + b;
            end
            mips_pkg::ALU_SUB: begin
                // Wraps modulo 2^32, no overflow trap.
                result = a - b;
            end
            mips_pkg::ALU_AND: begin
                result = a & b;
            end
            mips_pkg::ALU_OR: begin
                result = a | b;
            end
            mips_pkg::ALU_XOR: begin
                result = a ^ b;
            end
            default: begin
                result = a + b;
            end
        endcase
    end

endmodule

//--- hdl/mips_pkg.sv
package mips_pkg;

    // Data and address word.
    typedef logic [31:0] word_t;

    // First instruction fetch address.
    localparam word_t RESET_VECTOR = 32'h0000_0004;

    // Avalon master request, 70 bits.
    typedef struct packed {
        word_t       address;
        word_t       writedata;
        logic [3:0]  byteenable;
        logic        read;
        logic        write;
    } avalon_req_t;

    // Primary opcode field, instruction bits 31:26.
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B
    } opcode_e;

    // R-type function field, instruction bits 5:0.
    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26
    } funct_e;

    // Operations the ALU can perform.
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4
    } alu_op_e;

endpackage
